// ==== src/soc_pkg.sv ====
package soc_pkg;

    // ------------------------------
    // Bus and line geometry
    // ------------------------------
    localparam int XLEN        = 32;            // Byte address width
    localparam int CLSIZE      = 128;           // One line, four words
    localparam int LINE_BYTES  = CLSIZE / 8;    // 16 bytes per line
    localparam int OFFSET_BITS = $clog2(LINE_BYTES);  // Byte offset inside a line

    // Byte address as seen on both request ports
    typedef logic [XLEN-1:0]   addr_t;

    // Full cache line, the unit of every transfer
    typedef logic [CLSIZE-1:0] line_t;

    // ------------------------------
    // Arbiter FSM
    // ------------------------------
    typedef enum logic [1:0]
    {
        ARB_IDLE,   // Waiting for a pending port
        ARB_WAIT,   // Memory busy, waiting for done
        ARB_DONE    // Answer the granted port
    } arb_state_t;

endpackage

// ==== src/rst_stretch.sv ====
`timescale 1ns/100ps

module rst_stretch
#(
    parameter int RST_CYCLES = 8
)
(
    input  logic clk,
    input  logic rst,
    output logic sys_rst_o,
    output logic ready_o
);
    // Wide enough to hold RST_CYCLES itself
    localparam int CNT_W = (RST_CYCLES > 0) ? $clog2(RST_CYCLES + 1) : 1;

    logic [CNT_W-1:0] cnt_q;    // Cycles left before release

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cnt_q     <= CNT_W'(RST_CYCLES);    // Reload on every reset cycle
            sys_rst_o <= 1'b1;
            ready_o   <= 1'b0;
        end
        else
        begin
            if (cnt_q != '0)
                cnt_q <= cnt_q - 1'b1;          // Stick at zero
            sys_rst_o <= (cnt_q != '0);         // Registered, one edge after zero
            ready_o   <= (cnt_q == '0);
        end
    end

endmodule

// ==== src/mem_arbiter.sv ====
`timescale 1ns/100ps

module mem_arbiter
(
    input  logic           clk,
    input  logic           rst,

    // Instruction fetch port, reads only
    input  logic           imem_strobe_i,
    input  soc_pkg::addr_t imem_addr_i,
    output logic           imem_done_o,
    output soc_pkg::line_t imem_data_o,

    // Data port
    input  logic           dmem_strobe_i,
    input  soc_pkg::addr_t dmem_addr_i,
    input  logic           dmem_rw_i,       // High for write
    input  soc_pkg::line_t dmem_wdata_i,
    output logic           dmem_done_o,
    output soc_pkg::line_t dmem_rdata_o,

    // Line memory side
    output logic           mem_req_o,
    output logic           mem_we_o,
    output soc_pkg::addr_t mem_addr_o,
    output soc_pkg::line_t mem_wdata_o,
    input  logic           mem_done_i,
    input  soc_pkg::line_t mem_rdata_i
);
    import soc_pkg::*;

    arb_state_t state_q;

    logic  imem_pend_q;     // Fetch request waiting
    logic  dmem_pend_q;     // Data request waiting
    logic  imem_skip_q;     // Fetch was passed over once, goes next
    logic  gnt_dmem_q;      // Port owning the memory
    logic  sel_dmem;        // Grant choice in ARB_IDLE

    addr_t imem_addr_q;
    addr_t dmem_addr_q;
    logic  dmem_rw_q;
    line_t dmem_wdata_q;
    line_t imem_data_q;
    line_t dmem_rdata_q;

    // ------------------------------
    // Request capture
    // ------------------------------
    // Set wins over clear, so a strobe in the done cycle is not lost
    always_ff @(posedge clk)
    begin
        if (rst)
            imem_pend_q <= 1'b0;                // Strobes during reset dropped
        else if (imem_strobe_i)
            imem_pend_q <= 1'b1;
        else if (state_q == ARB_DONE && !gnt_dmem_q)
            imem_pend_q <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            dmem_pend_q <= 1'b0;
        else if (dmem_strobe_i)
            dmem_pend_q <= 1'b1;
        else if (state_q == ARB_DONE && gnt_dmem_q)
            dmem_pend_q <= 1'b0;
    end

    // Payload follows the strobe, held until served
    always_ff @(posedge clk)
    begin
        if (imem_strobe_i)
            imem_addr_q <= imem_addr_i;
        if (dmem_strobe_i)
        begin
            dmem_addr_q  <= dmem_addr_i;
            dmem_rw_q    <= dmem_rw_i;
            dmem_wdata_q <= dmem_wdata_i;
        end
    end

    // ------------------------------
    // Grant FSM
    // ------------------------------
    // Data first, unless fetch already lost one round
    assign sel_dmem = dmem_pend_q & ~imem_skip_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q     <= ARB_IDLE;
            gnt_dmem_q  <= 1'b0;
            imem_skip_q <= 1'b0;
        end
        else
        begin
            case (state_q)
                ARB_IDLE:
                    if (mem_req_o)
                    begin
                        state_q     <= ARB_WAIT;
                        gnt_dmem_q  <= sel_dmem;
                        imem_skip_q <= sel_dmem & imem_pend_q;  // Cleared on fetch grant
                    end
                ARB_WAIT:
                    if (mem_done_i)
                        state_q <= ARB_DONE;
                ARB_DONE:
                    state_q <= ARB_IDLE;                // Single cycle answer
                default:
                    state_q <= ARB_IDLE;
            endcase
        end
    end

    // Line captured as memory finishes, shown from ARB_DONE on
    always_ff @(posedge clk)
    begin
        if (state_q == ARB_WAIT && mem_done_i)
        begin
            if (gnt_dmem_q)
                dmem_rdata_q <= mem_rdata_i;
            else
                imem_data_q  <= mem_rdata_i;
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------
    assign mem_req_o   = (state_q == ARB_IDLE) & (imem_pend_q | dmem_pend_q);   // One cycle
    assign mem_we_o    = sel_dmem & dmem_rw_q;  // Fetch never writes
    assign mem_addr_o  = sel_dmem ? dmem_addr_q : imem_addr_q;
    assign mem_wdata_o = dmem_wdata_q;

    assign imem_done_o  = (state_q == ARB_DONE) & ~gnt_dmem_q;
    assign dmem_done_o  = (state_q == ARB_DONE) & gnt_dmem_q;
    assign imem_data_o  = imem_data_q;
    assign dmem_rdata_o = dmem_rdata_q;

endmodule

// ==== src/line_mem.sv ====
`timescale 1ns/100ps

module line_mem
#(
    parameter int MEM_LINES   = 256,    // Power of two
    parameter int MEM_LATENCY = 3       // Request to done, at least 1
)
(
    input  logic           clk,
    input  logic           rst,
    input  logic           req_i,       // One cycle pulse
    input  logic           we_i,
    input  soc_pkg::addr_t addr_i,
    input  soc_pkg::line_t wdata_i,
    output logic           done_o,
    output soc_pkg::line_t rdata_o
);
    import soc_pkg::*;

    localparam int IDX_BITS = (MEM_LINES > 1) ? $clog2(MEM_LINES) : 1;

    line_t                  mem_q [MEM_LINES];  // Line storage, contents survive reset
    line_t                  rdata_q;
    logic [IDX_BITS-1:0]    idx;
    logic [MEM_LATENCY-1:0] done_sr_q;          // Request travelling toward done

    // Bits right above the byte offset, upper bits alias
    assign idx = addr_i[OFFSET_BITS +: IDX_BITS];

    // ------------------------------
    // Array access at the request edge
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (req_i)
        begin
            if (we_i)
                mem_q[idx] <= wdata_i;      // Write lands right away
            else
                rdata_q    <= mem_q[idx];   // Held until the next read
        end
    end

    // ------------------------------
    // Latency pipe
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
            done_sr_q <= '0;
        else
        begin
            done_sr_q[0] <= req_i;
            for (int i = 1; i < MEM_LATENCY; i++)
            begin
                done_sr_q[i] <= done_sr_q[i-1];
            end
        end
    end

    assign done_o  = done_sr_q[MEM_LATENCY-1];  // Exactly MEM_LATENCY after req
    assign rdata_o = rdata_q;

endmodule

// ==== src/mem_sys_top.sv ====
`timescale 1ns/100ps

module mem_sys_top
#(
    parameter int MEM_LINES   = 256,
    parameter int MEM_LATENCY = 3,
    parameter int RST_CYCLES  = 8
)
(
    input  logic           clk,
    input  logic           rst,
    output logic           ready_o,         // Memory system out of reset

    // Instruction fetch port
    input  logic           imem_strobe_i,
    input  soc_pkg::addr_t imem_addr_i,
    output logic           imem_done_o,
    output soc_pkg::line_t imem_data_o,

    // Data port
    input  logic           dmem_strobe_i,
    input  soc_pkg::addr_t dmem_addr_i,
    input  logic           dmem_rw_i,
    input  soc_pkg::line_t dmem_wdata_i,
    output logic           dmem_done_o,
    output soc_pkg::line_t dmem_rdata_o
);
    import soc_pkg::*;

    logic  sys_rst;     // Stretched reset for arbiter and memory

    // Arbiter to line memory
    logic  mem_req;
    logic  mem_we;
    addr_t mem_addr;
    line_t mem_wdata;
    logic  mem_done;
    line_t mem_rdata;

    // ------------------------------
    // Reset stretch
    // ------------------------------
    rst_stretch #(
        .RST_CYCLES (RST_CYCLES)
    ) rst_stretch_inst (
        .clk       (clk),
        .rst       (rst),
        .sys_rst_o (sys_rst),
        .ready_o   (ready_o)
    );

    // ------------------------------
    // Port arbitration
    // ------------------------------
    mem_arbiter mem_arbiter_inst (
        .clk           (clk),
        .rst           (sys_rst),       // Also drops strobes before ready
        .imem_strobe_i (imem_strobe_i),
        .imem_addr_i   (imem_addr_i),
        .imem_done_o   (imem_done_o),
        .imem_data_o   (imem_data_o),
        .dmem_strobe_i (dmem_strobe_i),
        .dmem_addr_i   (dmem_addr_i),
        .dmem_rw_i     (dmem_rw_i),
        .dmem_wdata_i  (dmem_wdata_i),
        .dmem_done_o   (dmem_done_o),
        .dmem_rdata_o  (dmem_rdata_o),
        .mem_req_o     (mem_req),
        .mem_we_o      (mem_we),
        .mem_addr_o    (mem_addr),
        .mem_wdata_o   (mem_wdata),
        .mem_done_i    (mem_done),
        .mem_rdata_i   (mem_rdata)
    );

    // ------------------------------
    // Line storage
    // ------------------------------
    line_mem #(
        .MEM_LINES   (MEM_LINES),
        .MEM_LATENCY (MEM_LATENCY)
    ) line_mem_inst (
        .clk     (clk),
        .rst     (sys_rst),
        .req_i   (mem_req),
        .we_i    (mem_we),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .done_o  (mem_done),
        .rdata_o (mem_rdata)
    );

endmodule

// ==== tests/tb_mem_sys_top.sv ====
`timescale 1ns/100ps

module tb_mem_sys_top;
    import soc_pkg::*;

    localparam int MEM_LINES   = 256;
    localparam int MEM_LATENCY = 3;
    localparam int RST_CYCLES  = 8;
    localparam int IDX_BITS    = $clog2(MEM_LINES);
    localparam int DONE_LIMIT  = 2 * (MEM_LATENCY + 6);    // Room for one lost round
    localparam int PORT_I      = 0;
    localparam int PORT_D      = 1;
    localparam int PORT_BOTH   = 2;                        // Same cycle strobe on both

    logic  clk;
    logic  rst;
    logic  ready;
    logic  imem_strobe;
    addr_t imem_addr;
    logic  imem_done;
    line_t imem_data;
    logic  dmem_strobe;
    addr_t dmem_addr;
    logic  dmem_rw;
    line_t dmem_wdata;
    logic  dmem_done;
    line_t dmem_rdata;

    // Stimulus table with one entry per transaction
    int    row_port [$];
    logic  row_rw [$];
    addr_t row_addr [$];
    line_t row_wdata [$];
    line_t row_exp [$];

    line_t       model_mem [MEM_LINES];                    // Expected lines by index
    logic [31:0] lcg_state    = 32'h50ef7021;
    int          mismatch_cnt = 0;
    int          other_cnt    = 0;

    mem_sys_top #(
        .MEM_LINES   (MEM_LINES),
        .MEM_LATENCY (MEM_LATENCY),
        .RST_CYCLES  (RST_CYCLES)
    ) mem_sys_top_inst (
        .clk           (clk),
        .rst           (rst),
        .ready_o       (ready),
        .imem_strobe_i (imem_strobe),
        .imem_addr_i   (imem_addr),
        .imem_done_o   (imem_done),
        .imem_data_o   (imem_data),
        .dmem_strobe_i (dmem_strobe),
        .dmem_addr_i   (dmem_addr),
        .dmem_rw_i     (dmem_rw),
        .dmem_wdata_i  (dmem_wdata),
        .dmem_done_o   (dmem_done),
        .dmem_rdata_o  (dmem_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;                            // 40 ns period
    end

    // ------------------------------
    // Helpers and compare tasks
    // ------------------------------
    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Index bits sit right above the byte offset
    function automatic int line_index(addr_t addr);
        return int'(addr[OFFSET_BITS +: IDX_BITS]);
    endfunction

    function automatic addr_t make_addr(int idx, int offset, int upper);
        return (addr_t'(upper) << (OFFSET_BITS + IDX_BITS))
               | (addr_t'(idx) << OFFSET_BITS) | addr_t'(offset);
    endfunction

    task automatic step();
        @(posedge clk);
        #2;                                                // Drive point
    endtask

    task automatic check_line(string name, line_t got, line_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic check_cycles(string name, int got, int exp);
        if (got != exp)
        begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic expect_no_done();
        check_flag("imem_done_o", imem_done, 1'b0);
        check_flag("dmem_done_o", dmem_done, 1'b0);
    endtask

    // ------------------------------
    // Stimulus table
    // ------------------------------
    task automatic add_row(int port, logic rw, addr_t addr);
        line_t wdata;
        line_t exp;
        exp = '0;
        for (int w = 0; w < CLSIZE / 32; w++)
            wdata[w*32 +: 32] = lcg_next();
        if (rw)
            model_mem[line_index(addr)] = wdata;           // Model follows the write
        else
            exp = model_mem[line_index(addr)];
        row_port.push_back(port);
        row_rw.push_back(rw);
        row_addr.push_back(addr);
        row_wdata.push_back(wdata);
        row_exp.push_back(exp);
    endtask

    task automatic build_table();
        add_row(PORT_D, 1'b1, make_addr(3, 0, 0));
        add_row(PORT_D, 1'b1, make_addr(17, 0, 0));
        add_row(PORT_D, 1'b1, make_addr(100, 0, 0));
        add_row(PORT_D, 1'b1, make_addr(MEM_LINES - 1, 0, 0));
        add_row(PORT_D, 1'b1, make_addr(42, 8, 0));        // Offset ignored on write
        add_row(PORT_D, 1'b0, make_addr(3, 0, 0));
        add_row(PORT_D, 1'b0, make_addr(17, 12, 0));       // Same line, other offset
        add_row(PORT_D, 1'b0, make_addr(100, 0, 0));
        add_row(PORT_D, 1'b0, make_addr(MEM_LINES - 1, 15, 0));
        add_row(PORT_I, 1'b0, make_addr(42, 0, 0));        // Fetch sees data writes
        add_row(PORT_I, 1'b0, make_addr(3, 4, 0));
        add_row(PORT_D, 1'b0, make_addr(100, 0, 1));       // Alias above the index
        add_row(PORT_I, 1'b0, make_addr(MEM_LINES - 1, 0, 'h80000));
        add_row(PORT_D, 1'b1, make_addr(3, 0, 'h5a));      // Overwrite through alias
        add_row(PORT_I, 1'b0, make_addr(3, 0, 0));
        add_row(PORT_BOTH, 1'b0, make_addr(17, 0, 0));
        add_row(PORT_BOTH, 1'b0, make_addr(42, 4, 3));
    endtask

    // ------------------------------
    // Reset and stretch
    // ------------------------------
    task automatic reset_phase();
        for (int i = 0; i < 10; i++)
        begin
            step();
            if (i == 9)
                rst = 1'b0;                                // Next edge samples it low
            @(negedge clk);
            check_flag("ready_o", ready, 1'b0);
            if (i >= 2)
                expect_no_done();                          // Stretched reset settled
        end
        for (int k = 1; k <= RST_CYCLES + 1; k++)
        begin
            step();
            imem_strobe = (k == 1);                        // Dropped while not ready
            dmem_strobe = (k == 1);
            dmem_rw     = (k == 1);                        // A write that must not land
            dmem_wdata  = '1;
            @(negedge clk);
            check_flag("ready_o", ready, (k == RST_CYCLES + 1));
            expect_no_done();
        end
        for (int k = 0; k < MEM_LATENCY + 4; k++)
        begin
            step();
            @(negedge clk);
            expect_no_done();
        end
    endtask

    // ------------------------------
    // One table row
    // ------------------------------
    task automatic run_row(int r);
        bit want_i;
        bit want_d;
        int i_at;
        int d_at;
        int cycles;
        want_i = (row_port[r] != PORT_D);
        want_d = (row_port[r] != PORT_I);
        i_at   = -1;
        d_at   = -1;
        cycles = 0;
        step();
        imem_strobe = want_i;
        imem_addr   = row_addr[r];
        dmem_strobe = want_d;
        dmem_addr   = row_addr[r];
        dmem_rw     = row_rw[r];
        dmem_wdata  = row_wdata[r];
        step();
        imem_strobe = 1'b0;                                // Single cycle strobe
        dmem_strobe = 1'b0;
        // Cycles counted from the strobe cycle
        while (cycles < DONE_LIMIT && ((want_d && d_at < 0) || (want_i && i_at < 0)))
        begin
            @(negedge clk);
            cycles++;
            if (dmem_done === 1'b1 && want_d && d_at < 0)
            begin
                d_at = cycles;
                if (!row_rw[r])
                    check_line("dmem_rdata_o", dmem_rdata, row_exp[r]);
            end
            else
                check_flag("dmem_done_o", dmem_done, 1'b0);    // No stray pulse
            if (imem_done === 1'b1 && want_i && i_at < 0)
            begin
                i_at = cycles;
                check_line("imem_data_o", imem_data, row_exp[r]);
            end
            else
                check_flag("imem_done_o", imem_done, 1'b0);
        end
        if (want_d && d_at < 0)
        begin
            $display("Row %0d: no done on the data port within %0d cycles", r, DONE_LIMIT);
            other_cnt++;
        end
        if (want_i && i_at < 0)
        begin
            $display("Row %0d: no done on the fetch port within %0d cycles", r, DONE_LIMIT);
            other_cnt++;
        end
        if (row_port[r] == PORT_BOTH)
        begin
            if (d_at >= 0 && i_at >= 0 && d_at >= i_at)
            begin
                $display("Row %0d: data port done at cycle %0d, not before fetch done at %0d",
                         r, d_at, i_at);
                other_cnt++;
            end
        end
        else if (want_d && d_at >= 0)
            check_cycles("dmem_done_o latency", d_at, MEM_LATENCY + 2);
        else if (want_i && i_at >= 0)
            check_cycles("imem_done_o latency", i_at, MEM_LATENCY + 2);
    endtask

    // ------------------------------
    // Main sequence and watchdog
    // ------------------------------
    initial
    begin : main_seq
        rst         = 1'b1;
        imem_strobe = 1'b0;
        imem_addr   = '0;
        dmem_strobe = 1'b0;
        dmem_addr   = '0;
        dmem_rw     = 1'b0;
        dmem_wdata  = '0;
        build_table();
        reset_phase();
        for (int r = 0; r < row_port.size(); r++)
            run_row(r);
        step();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin : watchdog
        int limit;
        int cycle_cnt;
        cycle_cnt = 0;
        @(posedge clk);                                    // Table built by now
        limit = row_port.size() * (MEM_LATENCY + 6) + 2 * (RST_CYCLES + 10);
        while (cycle_cnt < limit)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run still busy after %0d cycles", cycle_cnt);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt + 1);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== src.f ====
src/soc_pkg.sv
src/rst_stretch.sv
src/mem_arbiter.sv
src/line_mem.sv
src/mem_sys_top.sv
tests/tb_mem_sys_top.sv

// ==== Bender.yml ====
package:
  name: mem_sys

sources:
  - src/soc_pkg.sv
  - src/rst_stretch.sv
  - src/mem_arbiter.sv
  - src/line_mem.sv
  - src/mem_sys_top.sv
  - target: test
    files:
      - tests/tb_mem_sys_top.sv
